//--- hdl/snes_mem_pkg.sv
////////////////////////////////////////////////////////////////////////////
// memory front end shared definitions
// widths, address map, loader word format and menu bridge states
////////////////////////////////////////////////////////////////////////////
package snes_mem_pkg;

    localparam int ADDR_W      = 23;               // byte address, 8 MB
    localparam int WORD_W      = 16;
    localparam int BYTE_W      = 8;
    localparam int WRAM_ADDR_W = 17;               // 128 KB of work ram
    localparam int MEM_WORDS   = 1 << (ADDR_W - 1);

    // wram lives in banks 7E/7F, the top 128 KB
    localparam logic [ADDR_W-WRAM_ADDR_W-1:0] WRAM_BANK = '1;

    // accept to ack toggle
    localparam int MEM_LATENCY = 3;
    localparam int LAT_CNT_W   = $clog2(MEM_LATENCY);

    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [BYTE_W-1:0]      byte_t;
    typedef logic [WRAM_ADDR_W-1:0] wram_addr_t;

    // one assembled loader word
    typedef struct packed {
        logic  valid;   // new word this cycle
        addr_t addr;    // even byte address
        word_t data;    // odd byte high, even byte low
    } load_word_t;

    // 32-to-16 bridge states
    typedef enum logic [2:0] {
        idle_req0  = 3'd0,
        wait0_req1 = 3'd1,
        data0      = 3'd2,
        wait1      = 3'd3,
        data1      = 3'd4
    } rv_state_e;

endpackage

//--- hdl/mem_chan_if.sv
////////////////////////////////////////////////////////////////////////////
// word memory channel with toggle request/acknowledge
////////////////////////////////////////////////////////////////////////////
interface mem_chan_if
    import snes_mem_pkg::*;
();

    logic       req;    // toggles once per request
    addr_t      addr;   // bit 0 ignored
    word_t      din;
    logic [1:0] ds;     // byte enables, bit 1 is the high byte
    logic       we;
    logic       ack;    // follows req when served
    word_t      dout;   // valid from the ack toggle on

    // pending while req and ack differ
    modport host (
        output req, addr, din, ds, we,
        input  ack, dout
    );

    modport mem (
        input  req, addr, din, ds, we,
        output ack, dout
    );

endinterface

//--- hdl/rom_loader.sv
////////////////////////////////////////////////////////////////////////////
// rom loader, packs the incoming byte stream into 16-bit word writes
// and raises loaded once the stream ends
////////////////////////////////////////////////////////////////////////////
module rom_loader import snes_mem_pkg::*; (
    input  logic       mclk,
    input  logic       resetn,
    input  logic       loading,
    input  byte_t      loader_data,
    input  logic       loader_valid,
    output load_word_t load_word,
    output logic       loaded
);

    addr_t byte_addr;       // address of the next byte
    byte_t prev_byte;       // even byte waiting for its partner
    logic  loading_r;
    logic  word_valid;
    addr_t word_addr;
    word_t word_data;
    logic  take_byte;

    assign take_byte = loading & loader_valid;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            loading_r  <= 1'b0;
            loaded     <= 1'b0;
            byte_addr  <= '0;
            word_valid <= 1'b0;
        end else begin
            loading_r  <= loading;
            word_valid <= take_byte & byte_addr[0];    // odd byte completes a word
            if (take_byte)
                byte_addr <= byte_addr + 1'b1;
            // a new load starts over from byte 0
            if (loading & ~loading_r) begin
                byte_addr <= '0;
                loaded    <= 1'b0;
            end
            if (~loading & loading_r)
                loaded <= 1'b1;
        end
    end

    always_ff @(posedge mclk) begin
        if (take_byte) begin
            prev_byte <= loader_data;
            word_addr <= {byte_addr[ADDR_W-1:1], 1'b0};
            word_data <= {loader_data, prev_byte};
        end
    end

    assign load_word = '{valid: word_valid, addr: word_addr, data: word_data};

    // bus capture only takes loader words while loading is still high
    a_word_while_loading: assert property (@(posedge mclk) disable iff (!resetn)
        load_word.valid |-> loading);

endmodule

//--- hdl/cpu_bus_capture.sv
////////////////////////////////////////////////////////////////////////////
// console bus capture, turns rom/wram strobes and loader words into
// channel requests and formats the returned words for the cpu
////////////////////////////////////////////////////////////////////////////
module cpu_bus_capture import snes_mem_pkg::*; (
    input  logic       mclk,
    input  logic       resetn,
    input  logic       loading,
    input  load_word_t load_word,
    input  addr_t      rom_addr,
    input  logic       rom_ce_n,
    input  logic       rom_word,
    output word_t      rom_q,
    input  wram_addr_t wram_addr,
    input  logic       wram_ce_n,
    input  logic       wram_rd_n,
    input  logic       wram_we_n,
    input  byte_t      wram_d,
    output byte_t      wram_q,
    mem_chan_if.host   chan
);

    logic       wram_rd, wram_wr;
    logic       wram_rd_r, wram_wr_r;
    wram_addr_t wram_addr_sd;       // last wram address sent
    addr_t      rom_addr_sd;        // last rom address sent
    logic       rom_sd_valid;       // rom_addr_sd holds a real address
    logic       issue_load, issue_wram, issue_rom, issue_any;
    logic       busy;
    logic       port_sel;           // 0 rom, 1 wram
    word_t      rom_data, wram_data;

    assign wram_rd = ~wram_ce_n & ~wram_rd_n;
    assign wram_wr = ~wram_ce_n & ~wram_we_n;

    // loader first, then wram, then rom
    assign issue_load = loading & load_word.valid;
    assign issue_wram = ~issue_load &
        ((wram_rd & (wram_addr[WRAM_ADDR_W-1:1] != wram_addr_sd[WRAM_ADDR_W-1:1]))
         | (wram_rd & ~wram_rd_r)
         | (wram_wr & ~wram_wr_r));
    assign issue_rom  = ~loading & ~issue_wram & ~rom_ce_n &
        (~rom_sd_valid | (rom_addr != rom_addr_sd));
    assign issue_any  = issue_load | issue_wram | issue_rom;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            chan.req     <= 1'b0;
            busy         <= 1'b0;
            wram_rd_r    <= 1'b0;
            wram_wr_r    <= 1'b0;
            rom_sd_valid <= 1'b0;
        end else begin
            wram_rd_r <= wram_rd;
            wram_wr_r <= wram_wr;
            if (busy && chan.req == chan.ack)
                busy <= 1'b0;
            if (loading)
                rom_sd_valid <= 1'b0;   // rom contents are changing
            else if (issue_rom)
                rom_sd_valid <= 1'b1;
            if (issue_any) begin
                chan.req <= ~chan.req;
                busy     <= 1'b1;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (issue_load) begin
            chan.addr <= load_word.addr;
            chan.din  <= load_word.data;
            chan.ds   <= 2'b11;
            chan.we   <= 1'b1;
            port_sel  <= 1'b0;
        end else if (issue_wram) begin
            wram_addr_sd <= wram_addr;
            chan.addr    <= {WRAM_BANK, wram_addr};
            chan.din     <= {wram_d, wram_d};                 // lane picked by ds
            chan.ds      <= {wram_addr[0], ~wram_addr[0]};
            chan.we      <= wram_wr;
            port_sel     <= 1'b1;
        end else if (issue_rom) begin
            rom_addr_sd <= rom_addr;
            chan.addr   <= rom_addr;
            chan.ds     <= 2'b11;
            chan.we     <= 1'b0;
            port_sel    <= 1'b0;
        end
    end

    // latch read data once the request is served
    always_ff @(posedge mclk) begin
        if (busy && chan.req == chan.ack && !chan.we) begin
            if (port_sel)
                wram_data <= chan.dout;
            else
                rom_data <= chan.dout;
        end
    end

    // byte reads from an odd rom address want the high byte in the low lane
    assign rom_q  = (rom_word | ~rom_addr[0]) ? rom_data : {rom_data[7:0], rom_data[15:8]};
    assign wram_q = wram_addr[0] ? wram_data[15:8] : wram_data[7:0];

endmodule

//--- hdl/rv_bridge.sv
////////////////////////////////////////////////////////////////////////////
// menu processor bridge, splits each 32-bit access into two 16-bit
// channel requests, one for half-word writes
////////////////////////////////////////////////////////////////////////////
module rv_bridge import snes_mem_pkg::*; (
    input  logic        mclk,
    input  logic        resetn,
    input  logic        rv_valid,
    output logic        rv_ready,
    input  addr_t       rv_addr,
    input  logic [31:0] rv_wdata,
    input  logic [3:0]  rv_wstrb,
    output logic [31:0] rv_rdata,
    mem_chan_if.host    chan
);

    rv_state_e  state;
    logic       rv_valid_r;
    logic       new_req;        // access arrived while busy
    logic       new_req_t;      // rising edge of rv_valid
    logic       write;
    logic       word_sel;       // 0 low word, 1 high word
    logic [1:0] ds;
    word_t      dout0;          // low word of a read

    assign write     = rv_wstrb != 4'b0000;
    assign new_req_t = rv_valid & ~rv_valid_r;

    assign chan.addr = {rv_addr[ADDR_W-1:2], word_sel, 1'b0};
    assign chan.din  = word_sel ? rv_wdata[31:16] : rv_wdata[15:0];
    assign chan.ds   = ds;
    assign chan.we   = write;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            state      <= idle_req0;
            rv_ready   <= 1'b0;
            rv_valid_r <= 1'b0;
            new_req    <= 1'b0;
            chan.req   <= 1'b0;
            word_sel   <= 1'b0;
            ds         <= 2'b00;
        end else begin
            rv_valid_r <= rv_valid;
            rv_ready   <= 1'b0;
            if (new_req_t)
                new_req <= 1'b1;

            case (state)
            idle_req0: begin
                if (new_req || new_req_t) begin
                    new_req  <= 1'b0;
                    chan.req <= ~chan.req;
                    if (write && rv_wstrb[1:0] == 2'b00) begin
                        word_sel <= 1'b1;       // upper half only
                        ds       <= rv_wstrb[3:2];
                        state    <= wait1;
                    end else begin
                        word_sel <= 1'b0;
                        ds       <= write ? rv_wstrb[1:0] : 2'b11;
                        state    <= wait0_req1;
                    end
                end
            end

            wait0_req1: begin
                if (chan.req == chan.ack) begin
                    if (write && rv_wstrb[3:2] == 2'b00) begin
                        rv_ready <= 1'b1;       // lower half only, done
                        state    <= idle_req0;
                    end else begin
                        chan.req <= ~chan.req;
                        word_sel <= 1'b1;
                        ds       <= write ? rv_wstrb[3:2] : 2'b11;
                        state    <= write ? wait1 : data0;
                    end
                end
            end

            data0: state <= wait1;              // low word captured below

            wait1: begin
                if (chan.req == chan.ack) begin
                    if (write) begin
                        rv_ready <= 1'b1;
                        state    <= idle_req0;
                    end else begin
                        state <= data1;
                    end
                end
            end

            data1: begin
                rv_ready <= 1'b1;
                state    <= idle_req0;
            end

            default: state <= idle_req0;
            endcase
        end
    end

    // low word holds until the high word is acknowledged
    always_ff @(posedge mclk) begin
        if (state == data0)
            dout0 <= chan.dout;
    end

    assign rv_rdata = {chan.dout, dout0};

    a_ready_pulse: assert property (@(posedge mclk) disable iff (!resetn)
        rv_ready |=> !rv_ready);

endmodule

//--- hdl/word_mem_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// two-channel word memory, fixed latency, console channel first
////////////////////////////////////////////////////////////////////////////
module word_mem_ctrl import snes_mem_pkg::*; (
    input  logic     mclk,
    input  logic     resetn,
    mem_chan_if.mem  cpu_chan,
    mem_chan_if.mem  rv_chan
);

    word_t                mem [MEM_WORDS];
    logic                 cpu_pend, rv_pend;
    logic                 busy;
    logic                 sel_rv;       // channel being served
    logic [LAT_CNT_W-1:0] lat_cnt;
    logic                 done;
    addr_t                m_addr;
    word_t                m_din;
    logic [1:0]           m_ds;
    logic                 m_we;
    logic [ADDR_W-2:0]    widx;

    assign cpu_pend = cpu_chan.req != cpu_chan.ack;
    assign rv_pend  = rv_chan.req != rv_chan.ack;
    assign done     = busy && lat_cnt == '0;

    // host keeps these stable until the ack
    assign m_addr = sel_rv ? rv_chan.addr : cpu_chan.addr;
    assign m_din  = sel_rv ? rv_chan.din  : cpu_chan.din;
    assign m_ds   = sel_rv ? rv_chan.ds   : cpu_chan.ds;
    assign m_we   = sel_rv ? rv_chan.we   : cpu_chan.we;
    assign widx   = m_addr[ADDR_W-1:1];

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            busy         <= 1'b0;
            sel_rv       <= 1'b0;
            lat_cnt      <= '0;
            cpu_chan.ack <= 1'b0;
            rv_chan.ack  <= 1'b0;
        end else if (!busy) begin
            if (cpu_pend || rv_pend) begin
                busy    <= 1'b1;
                sel_rv  <= ~cpu_pend;   // console wins a tie
                lat_cnt <= LAT_CNT_W'(MEM_LATENCY - 1);
            end
        end else if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - 1'b1;
        end else begin
            busy <= 1'b0;
            if (sel_rv)
                rv_chan.ack <= ~rv_chan.ack;
            else
                cpu_chan.ack <= ~cpu_chan.ack;
        end
    end

    always_ff @(posedge mclk) begin
        if (done) begin
            if (m_we) begin
                if (m_ds[0])
                    mem[widx][7:0] <= m_din[7:0];
                if (m_ds[1])
                    mem[widx][15:8] <= m_din[15:8];
            end else if (sel_rv) begin
                rv_chan.dout <= mem[widx];
            end else begin
                cpu_chan.dout <= mem[widx];
            end
        end
    end

    a_cpu_ack_pending: assert property (@(posedge mclk) disable iff (!resetn)
        $changed(cpu_chan.ack) |-> $past(cpu_chan.req != cpu_chan.ack));

    a_rv_ack_pending: assert property (@(posedge mclk) disable iff (!resetn)
        $changed(rv_chan.ack) |-> $past(rv_chan.req != rv_chan.ack));

endmodule

//--- hdl/snes_mem_top.sv
////////////////////////////////////////////////////////////////////////////
// memory front end top, loader, console bus and menu bus on one memory
////////////////////////////////////////////////////////////////////////////
module snes_mem_top import snes_mem_pkg::*; (
    input  logic        mclk,
    input  logic        resetn,
    // rom loader
    input  logic        loading,
    input  byte_t       loader_data,
    input  logic        loader_valid,
    output logic        loaded,
    // console rom
    input  addr_t       rom_addr,
    input  logic        rom_ce_n,
    input  logic        rom_word,
    output word_t       rom_q,
    // console wram
    input  wram_addr_t  wram_addr,
    input  logic        wram_ce_n,
    input  logic        wram_rd_n,
    input  logic        wram_we_n,
    input  byte_t       wram_d,
    output byte_t       wram_q,
    // menu processor
    input  logic        rv_valid,
    output logic        rv_ready,
    input  addr_t       rv_addr,
    input  logic [31:0] rv_wdata,
    input  logic [3:0]  rv_wstrb,
    output logic [31:0] rv_rdata
);

    load_word_t load_word;

    mem_chan_if cpu_chan ();
    mem_chan_if rv_chan ();

    rom_loader u_loader (
        .mclk(mclk), .resetn(resetn), .loading(loading),
        .loader_data(loader_data), .loader_valid(loader_valid),
        .load_word(load_word), .loaded(loaded)
    );

    cpu_bus_capture u_cpu_bus (
        .mclk(mclk), .resetn(resetn), .loading(loading), .load_word(load_word),
        .rom_addr(rom_addr), .rom_ce_n(rom_ce_n), .rom_word(rom_word), .rom_q(rom_q),
        .wram_addr(wram_addr), .wram_ce_n(wram_ce_n), .wram_rd_n(wram_rd_n),
        .wram_we_n(wram_we_n), .wram_d(wram_d), .wram_q(wram_q),
        .chan(cpu_chan.host)
    );

    rv_bridge u_rv_bridge (
        .mclk(mclk), .resetn(resetn),
        .rv_valid(rv_valid), .rv_ready(rv_ready), .rv_addr(rv_addr),
        .rv_wdata(rv_wdata), .rv_wstrb(rv_wstrb), .rv_rdata(rv_rdata),
        .chan(rv_chan.host)
    );

    word_mem_ctrl u_mem (
        .mclk(mclk), .resetn(resetn),
        .cpu_chan(cpu_chan.mem), .rv_chan(rv_chan.mem)
    );

endmodule

//--- dv/tb_snes_mem.sv
////////////////////////////////////////////////////////////////////////////
// memory front end testbench, directed loader, rom, wram and menu bus
// tests checked against a byte-wide model of the shared memory
////////////////////////////////////////////////////////////////////////////
module tb_snes_mem import snes_mem_pkg::*; ();

    localparam int LOAD_BYTES  = 32;
    localparam int BYTE_GAP    = 8;     // cycles between loader bytes
    localparam int READ_WAIT   = 10;    // console strobe hold time
    localparam int READY_LIMIT = 100;
    // tests take about 1500 cycles, leave a wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic        mclk;
    logic        resetn;
    logic        loading;
    byte_t       loader_data;
    logic        loader_valid;
    logic        loaded;
    addr_t       rom_addr;
    logic        rom_ce_n;
    logic        rom_word;
    word_t       rom_q;
    wram_addr_t  wram_addr;
    logic        wram_ce_n;
    logic        wram_rd_n;
    logic        wram_we_n;
    byte_t       wram_d;
    byte_t       wram_q;
    logic        rv_valid;
    logic        rv_ready;
    addr_t       rv_addr;
    logic [31:0] rv_wdata;
    logic [3:0]  rv_wstrb;
    logic [31:0] rv_rdata;

    byte_t  ref_mem [addr_t];   // expected contents by byte address
    integer seed;
    int     errors;
    int     cycles = 0;

    snes_mem_top uut (.*);

    initial begin
        mclk = 1'b0;
        forever #10 mclk = ~mclk;
    end

    always @(posedge mclk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $fatal(1, "watchdog expired");
        end
    end

    task automatic stop_run(input string what);
        errors++;
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            stop_run($sformatf("ERR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp)
            stop_run($sformatf("ERR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_rdata(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            stop_run($sformatf("ERR %s got %h expected %h", name, got, exp));
    endtask

    // little endian, odd byte in the high lane
    function automatic word_t model_word(input addr_t a);
        return {ref_mem[{a[ADDR_W-1:1], 1'b1}], ref_mem[{a[ADDR_W-1:1], 1'b0}]};
    endfunction

    function automatic logic [31:0] model_dword(input addr_t a);
        return {ref_mem[a + 23'd3], ref_mem[a + 23'd2], ref_mem[a + 23'd1], ref_mem[a]};
    endfunction

    task automatic wram_write(input wram_addr_t wa, input byte_t d);
        wram_addr = wa;
        wram_d    = d;
        wram_ce_n = 1'b0;
        wram_we_n = 1'b0;
        repeat (READ_WAIT) @(negedge mclk);
        wram_we_n = 1'b1;
        wram_ce_n = 1'b1;
        @(negedge mclk);
        ref_mem[{WRAM_BANK, wa}] = d;
    endtask

    task automatic wram_read_check(input wram_addr_t wa);
        wram_addr = wa;
        wram_ce_n = 1'b0;
        wram_rd_n = 1'b0;
        repeat (READ_WAIT) @(negedge mclk);
        check_byte("wram_q", wram_q, ref_mem[{WRAM_BANK, wa}]);
        wram_rd_n = 1'b1;
        wram_ce_n = 1'b1;
        @(negedge mclk);
    endtask

    // one menu bus access, held until the ready pulse
    task automatic rv_access(input addr_t a, input logic [31:0] wdata,
                             input logic [3:0] strb, output logic [31:0] rdata);
        int n;
        rv_addr  = a;
        rv_wdata = wdata;
        rv_wstrb = strb;
        rv_valid = 1'b1;
        n = 0;
        do begin
            @(negedge mclk);
            n++;
            if (n > READY_LIMIT)
                stop_run("menu bridge never raised rv_ready");
        end while (rv_ready !== 1'b1);
        rdata    = rv_rdata;
        rv_valid = 1'b0;
        @(negedge mclk);    // valid low for a clean rising edge next time
        for (int i = 0; i < 4; i++) begin
            if (strb[i])
                ref_mem[a + addr_t'(i)] = wdata[8*i +: 8];
        end
    endtask

    task automatic load_rom_test();
        byte_t b;
        int    n;
        loading = 1'b1;
        repeat (2) @(negedge mclk);
        for (int i = 0; i < LOAD_BYTES; i++) begin
            b = byte_t'($random(seed));
            loader_data  = b;
            loader_valid = 1'b1;
            ref_mem[addr_t'(i)] = b;
            @(negedge mclk);
            loader_valid = 1'b0;
            repeat (BYTE_GAP - 1) @(negedge mclk);
        end
        if (loaded !== 1'b0)
            stop_run("loaded was high during the load");
        loading = 1'b0;
        n = 0;
        while (loaded !== 1'b1) begin
            @(negedge mclk);
            n++;
            if (n > 2)
                stop_run("loaded did not rise after loading fell");
        end
        rom_word = 1'b1;
        rom_ce_n = 1'b0;
        for (int a = 0; a < LOAD_BYTES; a += 2) begin
            rom_addr = addr_t'(a);
            repeat (READ_WAIT) @(negedge mclk);
            check_word("rom_q", rom_q, model_word(addr_t'(a)));
        end
    endtask

    task automatic rom_swap_test();
        addr_t a;
        rom_word = 1'b0;
        rom_ce_n = 1'b0;
        for (int i = 1; i < LOAD_BYTES; i += 6) begin
            a = addr_t'(i);
            rom_addr = a;
            repeat (READ_WAIT) @(negedge mclk);
            // byte at the odd address comes back in the low lane
            check_word("rom_q", rom_q, {ref_mem[a - 23'd1], ref_mem[a]});
        end
        rom_ce_n = 1'b1;
        rom_word = 1'b1;
        @(negedge mclk);
    endtask

    task automatic wram_test();
        wram_addr_t base;
        for (int k = 0; k < 4; k++) begin
            base    = wram_addr_t'($random(seed));
            base[0] = 1'b0;
            wram_write(base, byte_t'($random(seed)));
            wram_write(base | 17'd1, byte_t'($random(seed)));
            wram_read_check(base);
            wram_read_check(base | 17'd1);
            wram_write(base, byte_t'($random(seed)));   // odd lane must survive
            wram_read_check(base | 17'd1);
            wram_read_check(base);
            wram_write(base | 17'd1, byte_t'($random(seed)));
            wram_read_check(base);
            wram_read_check(base | 17'd1);
        end
    endtask

    task automatic menu_word_test();
        addr_t       a;
        wram_addr_t  wa;
        logic [31:0] rdata;
        for (int k = 0; k < 4; k++) begin
            a      = addr_t'($random(seed));
            a[1:0] = 2'b00;
            rv_access(a, 32'($random(seed)), 4'hf, rdata);
            rv_access(a, 32'h0, 4'h0, rdata);
            check_rdata("rv_rdata", rdata, model_dword(a));
        end
        // wram bytes seen through the menu bus
        wa      = wram_addr_t'($random(seed));
        wa[1:0] = 2'b00;
        for (int i = 0; i < 4; i++)
            wram_write(wa | wram_addr_t'(i), byte_t'($random(seed)));
        rv_access({WRAM_BANK, wa}, 32'h0, 4'h0, rdata);
        check_rdata("rv_rdata", rdata, model_dword({WRAM_BANK, wa}));
    endtask

    task automatic menu_partial_test();
        addr_t       a;
        logic [31:0] rdata;
        for (int k = 0; k < 2; k++) begin
            a      = addr_t'($random(seed));
            a[1:0] = 2'b00;
            rv_access(a, 32'($random(seed)), 4'hf, rdata);
            rv_access(a, 32'($random(seed)), 4'b0011, rdata);
            rv_access(a, 32'h0, 4'h0, rdata);
            check_rdata("rv_rdata", rdata, model_dword(a));
            rv_access(a, 32'($random(seed)), 4'b1100, rdata);
            rv_access(a, 32'h0, 4'h0, rdata);
            check_rdata("rv_rdata", rdata, model_dword(a));
        end
    endtask

    initial begin
        seed         = 32'hfc8edefc;
        errors       = 0;
        resetn       = 1'b0;
        loading      = 1'b0;
        loader_data  = '0;
        loader_valid = 1'b0;
        rom_addr     = '0;
        rom_ce_n     = 1'b1;
        rom_word     = 1'b1;
        wram_addr    = '0;
        wram_ce_n    = 1'b1;
        wram_rd_n    = 1'b1;
        wram_we_n    = 1'b1;
        wram_d       = '0;
        rv_valid     = 1'b0;
        rv_addr      = '0;
        rv_wdata     = '0;
        rv_wstrb     = '0;
        repeat (5) @(negedge mclk);
        resetn = 1'b1;
        repeat (2) @(negedge mclk);
        if (loaded !== 1'b0 || rv_ready !== 1'b0)
            stop_run("loaded or rv_ready not cleared by reset");
        load_rom_test();
        rom_swap_test();
        wram_test();
        menu_word_test();
        menu_partial_test();
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- vlog.f
hdl/snes_mem_pkg.sv
hdl/mem_chan_if.sv
hdl/rom_loader.sv
hdl/cpu_bus_capture.sv
hdl/rv_bridge.sv
hdl/word_mem_ctrl.sv
hdl/snes_mem_top.sv
dv/tb_snes_mem.sv

//--- Makefile
# Verilator build and run of the memory front end testbench

TOP = tb_snes_mem

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
